//--- list.f
rtl/cpu_types_pkg.sv
rtl/control_unit.sv
rtl/execute_unit.sv
rtl/register_file.sv
rtl/pc_unit.sv
rtl/cpu_core.sv
test/tb_cpu_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_cpu_core \
    -o sim_tb_cpu_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_cpu_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi

//--- test/cpu_golden.txt
// test instr rdata, then expected: imem_addr dmem_addr dmem_wdata dmem_wen halted
// dmem_addr and dmem_wdata apply to store rows only, where dmem_wen is 1
01 24010005 00000000 00000000 00000000 00000000 0 0
01 2402FFFD 00000000 00000004 00000000 00000000 0 0
01 3C031234 00000000 00000008 00000000 00000000 0 0
01 34635678 00000000 0000000C 00000000 00000000 0 0
01 24050100 00000000 00000010 00000000 00000000 0 0
01 00222021 00000000 00000014 00000000 00000000 0 0
01 ACA40000 00000000 00000018 00000100 00000002 1 0
01 00222022 00000000 0000001C 00000000 00000000 0 0
01 ACA40004 00000000 00000020 00000104 00000008 1 0
01 00612027 00000000 00000024 00000000 00000000 0 0
01 ACA4FFFC 00000000 00000028 000000FC EDCBA982 1 0
01 00622026 00000000 0000002C 00000000 00000000 0 0
01 ACA40008 00000000 00000030 00000108 EDCBA985 1 0
01 0041202A 00000000 00000034 00000000 00000000 0 0
01 ACA4000C 00000000 00000038 0000010C 00000001 1 0
01 0041202B 00000000 0000003C 00000000 00000000 0 0
01 ACA40010 00000000 00000040 00000110 00000000 1 0
01 00032100 00000000 00000044 00000000 00000000 0 0
01 ACA40014 00000000 00000048 00000114 23456780 1 0
01 00022202 00000000 0000004C 00000000 00000000 0 0
01 ACA40018 00000000 00000050 00000118 00FFFFFF 1 0
02 24050200 00000000 00000000 00000000 00000000 0 0
02 8CA60004 CAFEF00D 00000004 00000000 00000000 0 0
02 ACA60000 00000000 00000008 00000200 CAFEF00D 1 0
02 24000077 00000000 0000000C 00000000 00000000 0 0
02 ACA00008 00000000 00000010 00000208 00000000 1 0
02 8CA00000 12345678 00000014 00000000 00000000 0 0
02 ACA0000C 00000000 00000018 0000020C 00000000 1 0
03 24010007 00000000 00000000 00000000 00000000 0 0
03 24020007 00000000 00000004 00000000 00000000 0 0
03 10220002 00000000 00000008 00000000 00000000 0 0
03 14220005 00000000 00000014 00000000 00000000 0 0
03 10200003 00000000 00000018 00000000 00000000 0 0
03 1420FFFC 00000000 0000001C 00000000 00000000 0 0
03 AC020030 00000000 00000010 00000030 00000007 1 0
04 08000004 00000000 00000000 00000000 00000000 0 0
04 0C000010 00000000 00000010 00000000 00000000 0 0
04 AC1F0000 00000000 00000040 00000000 00000014 1 0
04 24010080 00000000 00000044 00000000 00000000 0 0
04 00200008 00000000 00000048 00000000 00000000 0 0
04 03E00008 00000000 00000080 00000000 00000000 0 0
04 AC010004 00000000 00000014 00000004 00000080 1 0
05 3C017FFF 00000000 00000000 00000000 00000000 0 0
05 20227FFF 00000000 00000004 00000000 00000000 0 0
05 AC020010 00000000 00000008 00000010 7FFF7FFF 1 0
05 00421820 00000000 0000000C 00000000 00000000 0 0
05 AC020014 00000000 0000000C 00000000 00000000 0 1
05 24010001 00000000 0000000C 00000000 00000000 0 1
06 24010009 00000000 00000000 00000000 00000000 0 0
06 FC000000 00000000 00000004 00000000 00000000 0 0
06 AC010000 00000000 00000004 00000000 00000000 0 1
06 08000008 00000000 00000004 00000000 00000000 0 1

//--- test/tb_cpu_core.sv
// ***********************************************************
// Testbench for the single-cycle core, replays golden cycles
// and checks PC, data memory port and halt outputs
// ***********************************************************
module tb_cpu_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int fields   = 8;
    localparam int max_rows = 64;
    localparam int clk_half = 10;

    // MIPS load word opcode
    localparam logic [5:0] lw_opcode = 6'b100011;

    logic                 CLK;
    logic                 rst_n;
    cpu_types_pkg::word_t imem_data;
    cpu_types_pkg::word_t dmem_rdata;
    cpu_types_pkg::word_t imem_addr;
    cpu_types_pkg::word_t dmem_addr;
    cpu_types_pkg::word_t dmem_wdata;
    logic                 dmem_ren;
    logic                 dmem_wen;
    logic                 halted;

    // Eight words per row, see the golden file header
    cpu_types_pkg::word_t golden [max_rows * fields];

    int    num_rows;
    int    num_tests;
    int    timeout_ns;
    int    row_idx;
    string cur_test;
    int    test_errors;
    int    total_checks;
    int    total_errors;
    int    tests_run;
    int    tests_failed;

    cpu_core UUT (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .imem_data  (imem_data),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .halted     (halted)
    );

    always #(clk_half) CLK = ~CLK;

    function automatic string test_name(input cpu_types_pkg::word_t num);
        case (num)
            1:       return "alu_ops";
            2:       return "load_and_r0";
            3:       return "branches";
            4:       return "jumps";
            5:       return "overflow_halt";
            6:       return "explicit_halt";
            default: return "unknown";
        endcase
    endfunction

    function automatic cpu_types_pkg::word_t golden_field(input int row, input int col);
        return golden[row * fields + col];
    endfunction

    task automatic check_word(input string what, input cpu_types_pkg::word_t expected,
                              input cpu_types_pkg::word_t actual);
        total_checks++;
        if (actual !== expected)
        begin
            test_errors++;
            $display("FAILED %s row %0d %s: expected %h, actual %h",
                     cur_test, row_idx, what, expected, actual);
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        total_checks++;
        if (actual !== expected)
        begin
            test_errors++;
            $display("FAILED %s row %0d %s: expected %b, actual %b",
                     cur_test, row_idx, what, expected, actual);
        end
    endtask

    task automatic report_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0)
            $display("test %s: ok", cur_test);
        else
        begin
            tests_failed++;
            $display("test %s: %0d error(s)", cur_test, test_errors);
        end
        test_errors = 0;
    endtask

    // Two cycles with rst_n low, returns on the releasing edge
    task automatic reset_core();
        @(posedge CLK);
        rst_n      <= 1'b0;
        imem_data  <= 32'd0;
        dmem_rdata <= 32'd0;
        repeat (2) @(posedge CLK);
    endtask

    initial
    begin
        cpu_types_pkg::word_t prev_test;
        cpu_types_pkg::word_t instr;
        logic                 exp_wen;
        logic                 exp_ren;
        logic                 exp_halted;

        CLK          = 1'b0;
        rst_n        = 1'b0;
        imem_data    = 32'd0;
        dmem_rdata   = 32'd0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < max_rows * fields; i++)
            golden[i] = 32'd0;
        $readmemh("test/cpu_golden.txt", golden);

        // Rows end at the first zero test number
        num_rows  = 0;
        num_tests = 0;
        prev_test = 32'd0;
        while (num_rows < max_rows && golden_field(num_rows, 0) != 32'd0)
        begin
            if (golden_field(num_rows, 0) != prev_test)
                num_tests++;
            prev_test = golden_field(num_rows, 0);
            num_rows++;
        end
        // Each test adds a reset of three edges
        timeout_ns = num_rows * 2 * clk_half + num_tests * 6 * clk_half + 200;
        if (num_rows == 0)
        begin
            total_errors++;
            $display("no stimulus rows could be read from test/cpu_golden.txt");
        end

        prev_test = 32'd0;
        for (int r = 0; r < num_rows; r++)
        begin
            row_idx = r;
            if (golden_field(r, 0) != prev_test)
            begin
                if (r != 0)
                    report_test();
                prev_test = golden_field(r, 0);
                cur_test  = test_name(prev_test);
                reset_core();
            end
            else
                @(posedge CLK);
            rst_n      <= 1'b1;
            imem_data  <= golden_field(r, 1);
            dmem_rdata <= golden_field(r, 2);

            @(negedge CLK);
            instr      = golden_field(r, 1);
            exp_wen    = (golden_field(r, 6) != 32'd0);
            exp_halted = (golden_field(r, 7) != 32'd0);
            // Loads strobe the read port unless the core is halted
            exp_ren    = (instr[31:26] == lw_opcode) && !exp_halted;
            check_word("imem_addr", golden_field(r, 3), imem_addr);
            check_bit("dmem_wen", exp_wen, dmem_wen);
            check_bit("dmem_ren", exp_ren, dmem_ren);
            check_bit("halted", exp_halted, halted);
            if (exp_wen)
            begin
                check_word("dmem_addr", golden_field(r, 4), dmem_addr);
                check_word("dmem_wdata", golden_field(r, 5), dmem_wdata);
            end
        end
        if (num_rows > 0)
            report_test();

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // Watchdog against a core or testbench that stops making progress
    initial
    begin
        wait (timeout_ns > 0);
        #(timeout_ns);
        $display("timeout: run did not complete within %0d ns", timeout_ns);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- rtl/cpu_core.sv
// ***********************************************************
// Single-cycle MIPS subset core, memories outside the core
// ***********************************************************
module cpu_core (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  cpu_types_pkg::word_t imem_data,
    input  cpu_types_pkg::word_t dmem_rdata,
    output cpu_types_pkg::word_t imem_addr,
    output cpu_types_pkg::word_t dmem_addr,
    output cpu_types_pkg::word_t dmem_wdata,
    output logic                 dmem_ren,
    output logic                 dmem_wen,
    output logic                 halted
);

    cpu_types_pkg::aluop_t     alu_op;
    cpu_types_pkg::portb_sel_t portb_sel;
    cpu_types_pkg::pc_sel_t    pc_sel;
    cpu_types_pkg::regw_sel_t  regw_sel;
    cpu_types_pkg::wb_sel_t    wb_sel;
    logic                      porta_sel;
    logic                      imm_ext_sel;
    logic                      reg_wen;
    logic                      br_en;
    logic                      halt;
    logic                      zf;
    logic                      of;
    cpu_types_pkg::word_t      rs_data;
    cpu_types_pkg::word_t      rt_data;
    cpu_types_pkg::word_t      imm_ext;
    cpu_types_pkg::word_t      wr_data;
    cpu_types_pkg::word_t      pc_plus4;

    control_unit u_control (
        .instr       (imem_data),
        .zf          (zf),
        .of          (of),
        .halted      (halted),
        .alu_op      (alu_op),
        .portb_sel   (portb_sel),
        .pc_sel      (pc_sel),
        .regw_sel    (regw_sel),
        .wb_sel      (wb_sel),
        .porta_sel   (porta_sel),
        .imm_ext_sel (imm_ext_sel),
        .mem_ren     (dmem_ren),
        .mem_wen     (dmem_wen),
        .reg_wen     (reg_wen),
        .br_en       (br_en),
        .halt        (halt)
    );

    // ALU result doubles as the data memory address
    execute_unit u_execute (
        .instr       (imem_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .pc_plus4    (pc_plus4),
        .mem_rdata   (dmem_rdata),
        .porta_sel   (porta_sel),
        .imm_ext_sel (imm_ext_sel),
        .portb_sel   (portb_sel),
        .alu_op      (alu_op),
        .wb_sel      (wb_sel),
        .alu_result  (dmem_addr),
        .imm_ext     (imm_ext),
        .wr_data     (wr_data),
        .zf          (zf),
        .of          (of)
    );

    register_file u_regs (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .rs_addr  (imem_data[25:21]),
        .rt_addr  (imem_data[20:16]),
        .rd_addr  (imem_data[15:11]),
        .regw_sel (regw_sel),
        .wen      (reg_wen),
        .wr_data  (wr_data),
        .rs_data  (rs_data),
        .rt_data  (dmem_wdata)
    );

    assign rt_data = dmem_wdata;

    pc_unit u_pc (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .pc_sel     (pc_sel),
        .br_en      (br_en),
        .halt       (halt),
        .imm_ext    (imm_ext),
        .rs_data    (rs_data),
        .jump_index (imem_data[25:0]),
        .pc         (imem_addr),
        .pc_plus4   (pc_plus4),
        .halted     (halted)
    );

endmodule

//--- rtl/pc_unit.sv
// ***********************************************************
// PC unit: program counter, halted flag and next-PC targets
// ***********************************************************
module pc_unit (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  cpu_types_pkg::pc_sel_t pc_sel,
    input  logic                   br_en,
    input  logic                   halt,
    input  cpu_types_pkg::word_t   imm_ext,
    input  cpu_types_pkg::word_t   rs_data,
    input  logic [25:0]            jump_index,
    output cpu_types_pkg::word_t   pc,
    output cpu_types_pkg::word_t   pc_plus4,
    output logic                   halted
);

    cpu_types_pkg::word_t br_target;
    cpu_types_pkg::word_t jump_target;
    cpu_types_pkg::word_t pc_next;

    assign pc_plus4    = pc + 32'd4;
    assign br_target   = pc_plus4 + {imm_ext[29:0], 2'b00};
    assign jump_target = {pc_plus4[31:28], jump_index, 2'b00};

    always_comb
    begin
        case (pc_sel)
            cpu_types_pkg::pc_reg:  pc_next = rs_data;
            cpu_types_pkg::pc_jump: pc_next = jump_target;
            default:                pc_next = br_en ? br_target : pc_plus4;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            pc     <= cpu_types_pkg::reset_pc;
            halted <= 1'b0;
        end
        else
        begin
            halted <= halted || halt;
            // PC stays on the halting instruction
            if (!halted && !halt)
                pc <= pc_next;
        end
    end

endmodule

//--- rtl/register_file.sv
// ***********************************************************
// Register file: 32 x 32-bit, two async reads, one sync write
// ***********************************************************
module register_file (
    input  logic                     CLK,
    input  logic                     rst_n,
    input  cpu_types_pkg::regbits_t  rs_addr,
    input  cpu_types_pkg::regbits_t  rt_addr,
    input  cpu_types_pkg::regbits_t  rd_addr,
    input  cpu_types_pkg::regw_sel_t regw_sel,
    input  logic                     wen,
    input  cpu_types_pkg::word_t     wr_data,
    output cpu_types_pkg::word_t     rs_data,
    output cpu_types_pkg::word_t     rt_data
);

    cpu_types_pkg::word_t    regs [32];
    cpu_types_pkg::regbits_t wr_addr;

    always_comb
    begin
        case (regw_sel)
            cpu_types_pkg::regw_rd:  wr_addr = rd_addr;
            cpu_types_pkg::regw_rt:  wr_addr = rt_addr;
            default:                 wr_addr = 5'd31;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= 32'd0;
        end
        else if (wen && wr_addr != 5'd0)
        begin
            // Register 0 is never written so it reads as zero
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

//--- rtl/execute_unit.sv
// ***********************************************************
// Execute unit: immediate extension, operand select, ALU with
// zero and overflow flags, and write-back data select
// ***********************************************************
module execute_unit (
    input  cpu_types_pkg::word_t      instr,
    input  cpu_types_pkg::word_t      rs_data,
    input  cpu_types_pkg::word_t      rt_data,
    input  cpu_types_pkg::word_t      pc_plus4,
    input  cpu_types_pkg::word_t      mem_rdata,
    input  logic                      porta_sel,
    input  logic                      imm_ext_sel,
    input  cpu_types_pkg::portb_sel_t portb_sel,
    input  cpu_types_pkg::aluop_t     alu_op,
    input  cpu_types_pkg::wb_sel_t    wb_sel,
    output cpu_types_pkg::word_t      alu_result,
    output cpu_types_pkg::word_t      imm_ext,
    output cpu_types_pkg::word_t      wr_data,
    output logic                      zf,
    output logic                      of
);

    cpu_types_pkg::word_t porta;
    cpu_types_pkg::word_t portb;

    // Zero or sign extension of the 16-bit immediate
    assign imm_ext = imm_ext_sel ? {{16{instr[15]}}, instr[15:0]} : {16'h0000, instr[15:0]};

    always_comb
    begin
        // Shifts by shamt operate on rt
        if (porta_sel)
            porta = imm_ext;
        else if (portb_sel == cpu_types_pkg::portb_shamt)
            porta = rt_data;
        else
            porta = rs_data;

        case (portb_sel)
            cpu_types_pkg::portb_rt:    portb = rt_data;
            cpu_types_pkg::portb_shamt: portb = {27'd0, instr[10:6]};
            cpu_types_pkg::portb_imm:   portb = imm_ext;
            default:                    portb = 32'd16;
        endcase
    end

    always_comb
    begin
        case (alu_op)
            cpu_types_pkg::ALU_SLL:  alu_result = porta << portb[4:0];
            cpu_types_pkg::ALU_SRL:  alu_result = porta >> portb[4:0];
            cpu_types_pkg::ALU_SUB:  alu_result = porta - portb;
            cpu_types_pkg::ALU_AND:  alu_result = porta & portb;
            cpu_types_pkg::ALU_OR:   alu_result = porta | portb;
            cpu_types_pkg::ALU_XOR:  alu_result = porta ^ portb;
            cpu_types_pkg::ALU_NOR:  alu_result = ~(porta | portb);
            cpu_types_pkg::ALU_SLT:  alu_result = {31'd0, $signed(porta) < $signed(portb)};
            cpu_types_pkg::ALU_SLTU: alu_result = {31'd0, porta < portb};
            default:                 alu_result = porta + portb;
        endcase
    end

    assign zf = (alu_result == 32'd0);

    // Signed overflow: operand signs vs result sign
    always_comb
    begin
        case (alu_op)
            cpu_types_pkg::ALU_ADD:
                of = (porta[31] == portb[31]) && (alu_result[31] != porta[31]);
            cpu_types_pkg::ALU_SUB:
                of = (porta[31] != portb[31]) && (alu_result[31] != porta[31]);
            default:
                of = 1'b0;
        endcase
    end

    always_comb
    begin
        case (wb_sel)
            cpu_types_pkg::wb_mem: wr_data = mem_rdata;
            cpu_types_pkg::wb_pc4: wr_data = pc_plus4;
            default:               wr_data = alu_result;
        endcase
    end

endmodule

//--- rtl/control_unit.sv
// ***********************************************************
// Control unit: decodes each instruction into datapath selects,
// enables, ALU operation, branch decision and halt request
// ***********************************************************
module control_unit (
    input  cpu_types_pkg::word_t      instr,
    input  logic                      zf,
    input  logic                      of,
    input  logic                      halted,
    output cpu_types_pkg::aluop_t     alu_op,
    output cpu_types_pkg::portb_sel_t portb_sel,
    output cpu_types_pkg::pc_sel_t    pc_sel,
    output cpu_types_pkg::regw_sel_t  regw_sel,
    output cpu_types_pkg::wb_sel_t    wb_sel,
    output logic                      porta_sel,
    output logic                      imm_ext_sel,
    output logic                      mem_ren,
    output logic                      mem_wen,
    output logic                      reg_wen,
    output logic                      br_en,
    output logic                      halt
);

    cpu_types_pkg::opcode_t opcode;
    cpu_types_pkg::funct_t  funct;
    logic                   is_rtype;
    logic                   writes_reg;
    logic                   stopped;

    always_comb
    begin
        opcode   = cpu_types_pkg::opcode_t'(instr[31:26]);
        funct    = cpu_types_pkg::funct_t'(instr[5:0]);
        is_rtype = (opcode == cpu_types_pkg::RTYPE);
    end

    // Explicit HALT, or signed overflow on the trapping adds
    assign halt = (opcode == cpu_types_pkg::HALT) ||
                  (is_rtype && (funct == cpu_types_pkg::ADD ||
                                funct == cpu_types_pkg::SUB) && of) ||
                  (opcode == cpu_types_pkg::ADDI && of);

    // No side effects once halted or while a halt is pending
    assign stopped = halted || halt;

    always_comb
    begin
        // Sign extension for arithmetic, memory and branch offsets
        case (opcode)
            cpu_types_pkg::ADDI, cpu_types_pkg::ADDIU, cpu_types_pkg::SLTI,
            cpu_types_pkg::SLTIU, cpu_types_pkg::LW, cpu_types_pkg::SW,
            cpu_types_pkg::BEQ, cpu_types_pkg::BNE:
                imm_ext_sel = 1'b1;
            default:
                imm_ext_sel = 1'b0;
        endcase

        if (is_rtype)
        begin
            if (funct == cpu_types_pkg::SLL || funct == cpu_types_pkg::SRL)
                portb_sel = cpu_types_pkg::portb_shamt;
            else
                portb_sel = cpu_types_pkg::portb_rt;
        end
        else
        begin
            case (opcode)
                cpu_types_pkg::BEQ, cpu_types_pkg::BNE:
                    portb_sel = cpu_types_pkg::portb_rt;
                cpu_types_pkg::LUI:
                    portb_sel = cpu_types_pkg::portb_16;
                default:
                    portb_sel = cpu_types_pkg::portb_imm;
            endcase
        end

        // LUI shifts the immediate itself
        porta_sel = (opcode == cpu_types_pkg::LUI);

        if (opcode == cpu_types_pkg::LW)
            wb_sel = cpu_types_pkg::wb_mem;
        else if (opcode == cpu_types_pkg::JAL)
            wb_sel = cpu_types_pkg::wb_pc4;
        else
            wb_sel = cpu_types_pkg::wb_alu;

        if (opcode == cpu_types_pkg::JAL)
            regw_sel = cpu_types_pkg::regw_r31;
        else if (is_rtype)
            regw_sel = cpu_types_pkg::regw_rd;
        else
            regw_sel = cpu_types_pkg::regw_rt;

        if (opcode == cpu_types_pkg::J || opcode == cpu_types_pkg::JAL)
            pc_sel = cpu_types_pkg::pc_jump;
        else if (is_rtype && funct == cpu_types_pkg::JR)
            pc_sel = cpu_types_pkg::pc_reg;
        else
            pc_sel = cpu_types_pkg::pc_seq;

        // Instructions that produce a register result
        case (opcode)
            cpu_types_pkg::RTYPE:
                writes_reg = (funct != cpu_types_pkg::JR);
            cpu_types_pkg::ADDI, cpu_types_pkg::ADDIU, cpu_types_pkg::SLTI,
            cpu_types_pkg::SLTIU, cpu_types_pkg::ANDI, cpu_types_pkg::ORI,
            cpu_types_pkg::XORI, cpu_types_pkg::LUI, cpu_types_pkg::LW,
            cpu_types_pkg::JAL:
                writes_reg = 1'b1;
            default:
                writes_reg = 1'b0;
        endcase

        reg_wen = writes_reg && !stopped;
        mem_ren = (opcode == cpu_types_pkg::LW) && !stopped;
        mem_wen = (opcode == cpu_types_pkg::SW) && !stopped;

        br_en = (opcode == cpu_types_pkg::BEQ && zf) ||
                (opcode == cpu_types_pkg::BNE && !zf);
    end

    always_comb
    begin
        if (is_rtype)
        begin
            case (funct)
                cpu_types_pkg::SLL:                     alu_op = cpu_types_pkg::ALU_SLL;
                cpu_types_pkg::SRL:                     alu_op = cpu_types_pkg::ALU_SRL;
                cpu_types_pkg::SUB, cpu_types_pkg::SUBU: alu_op = cpu_types_pkg::ALU_SUB;
                cpu_types_pkg::AND:                     alu_op = cpu_types_pkg::ALU_AND;
                cpu_types_pkg::OR:                      alu_op = cpu_types_pkg::ALU_OR;
                cpu_types_pkg::XOR:                     alu_op = cpu_types_pkg::ALU_XOR;
                cpu_types_pkg::NOR:                     alu_op = cpu_types_pkg::ALU_NOR;
                cpu_types_pkg::SLT:                     alu_op = cpu_types_pkg::ALU_SLT;
                cpu_types_pkg::SLTU:                    alu_op = cpu_types_pkg::ALU_SLTU;
                default:                                alu_op = cpu_types_pkg::ALU_ADD;
            endcase
        end
        else
        begin
            case (opcode)
                cpu_types_pkg::LUI:                     alu_op = cpu_types_pkg::ALU_SLL;
                cpu_types_pkg::ANDI:                    alu_op = cpu_types_pkg::ALU_AND;
                cpu_types_pkg::ORI:                     alu_op = cpu_types_pkg::ALU_OR;
                cpu_types_pkg::XORI:                    alu_op = cpu_types_pkg::ALU_XOR;
                cpu_types_pkg::BEQ, cpu_types_pkg::BNE: alu_op = cpu_types_pkg::ALU_SUB;
                cpu_types_pkg::SLTI:                    alu_op = cpu_types_pkg::ALU_SLT;
                cpu_types_pkg::SLTIU:                   alu_op = cpu_types_pkg::ALU_SLTU;
                // ADDI, ADDIU, LW, SW and the rest add
                default:                                alu_op = cpu_types_pkg::ALU_ADD;
            endcase
        end
    end

endmodule

//--- rtl/cpu_types_pkg.sv
// ***********************************************************
// CPU types package: word and field types, MIPS opcode and
// funct encodings, ALU operations and datapath select codes
// ***********************************************************
package cpu_types_pkg;

    // Data, address and instruction words
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regbits_t;

    // Standard MIPS opcodes, HALT uses the all-ones slot
    typedef enum logic [5:0] {
        RTYPE = 6'b000000,
        J     = 6'b000010,
        JAL   = 6'b000011,
        BEQ   = 6'b000100,
        BNE   = 6'b000101,
        ADDI  = 6'b001000,
        ADDIU = 6'b001001,
        SLTI  = 6'b001010,
        SLTIU = 6'b001011,
        ANDI  = 6'b001100,
        ORI   = 6'b001101,
        XORI  = 6'b001110,
        LUI   = 6'b001111,
        LW    = 6'b100011,
        SW    = 6'b101011,
        HALT  = 6'b111111
    } opcode_t;

    // R-type funct field
    typedef enum logic [5:0] {
        SLL  = 6'b000000,
        SRL  = 6'b000010,
        JR   = 6'b001000,
        ADD  = 6'b100000,
        ADDU = 6'b100001,
        SUB  = 6'b100010,
        SUBU = 6'b100011,
        AND  = 6'b100100,
        OR   = 6'b100101,
        XOR  = 6'b100110,
        NOR  = 6'b100111,
        SLT  = 6'b101010,
        SLTU = 6'b101011
    } funct_t;

    typedef enum logic [3:0] {
        ALU_SLL,
        ALU_SRL,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU
    } aluop_t;

    // Operand B source
    typedef logic [1:0] portb_sel_t;
    localparam portb_sel_t portb_rt    = 2'd0;
    localparam portb_sel_t portb_shamt = 2'd1;
    localparam portb_sel_t portb_imm   = 2'd2;
    localparam portb_sel_t portb_16    = 2'd3;

    // Write-back data source
    typedef logic [1:0] wb_sel_t;
    localparam wb_sel_t wb_alu = 2'd0;
    localparam wb_sel_t wb_mem = 2'd1;
    localparam wb_sel_t wb_pc4 = 2'd2;

    // Destination register
    typedef logic [1:0] regw_sel_t;
    localparam regw_sel_t regw_rd  = 2'd0;
    localparam regw_sel_t regw_rt  = 2'd1;
    localparam regw_sel_t regw_r31 = 2'd2;

    // Next PC source
    typedef logic [1:0] pc_sel_t;
    localparam pc_sel_t pc_seq  = 2'd0;
    localparam pc_sel_t pc_reg  = 2'd1;
    localparam pc_sel_t pc_jump = 2'd2;

    localparam word_t reset_pc = 32'h0000_0000;

endpackage
